// ==== Makefile ====
# Verilator flow for the block cache

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= tb_cache
RTL_TOP   ?= cache_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --timing

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TB_TOP) -f $(FILELIST)

# the log decides pass or fail
sim: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
+incdir+include
hw/cache_pkg.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
testbench/tb_clkgen.sv
testbench/tb_cache.sv

// ==== hw/cache_ctrl.sv ====
// cache controller FSM sequencing hits, victim write-back and line refill
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl
	import cache_pkg::*;
(
	input  wire       clk,
	input  wire       rst_n,
	input  wire       i_proc_read,
	input  wire       i_proc_write,
	input  wire       i_hit,
	input  wire way_t i_hit_way,
	input  wire way_t i_victim_way,
	input  wire       i_victim_valid,
	input  wire       i_mem_ready,
	output logic      o_proc_stall,
	output logic      o_touch,       // pointer update on hit
	output logic      o_word_we,
	output logic      o_fill,        // line and tag install
	output way_t      o_way,
	output logic      o_mem_read,
	output logic      o_mem_write,
	output logic      o_rdata_en
);

	cache_state_e state;
	cache_state_e state_nxt;
	way_t         victim_r;   // way being replaced
	logic         req;
	logic         miss;

	assign req  = i_proc_read | i_proc_write;
	assign miss = req & ~i_hit;

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			ST_READY: begin
				if (miss)
					state_nxt = i_victim_valid ? ST_WRITEBACK : ST_REFILL;
			end
			ST_WRITEBACK: begin
				if (i_mem_ready)
					state_nxt = ST_REFILL;
			end
			ST_REFILL: begin
				if (i_mem_ready)
					state_nxt = ST_READY;   // request hits next cycle
			end
			default: state_nxt = ST_READY;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_READY;
			victim_r <= '0;
		end else begin
			state <= state_nxt;
			if ((state == ST_READY) && miss)
				victim_r <= i_victim_way;   // held for the whole miss
		end
	end

	// ----------------------------------------
	// outputs
	// ----------------------------------------
	assign o_proc_stall = miss | (state != ST_READY);
	assign o_touch      = (state == ST_READY) & req & i_hit;
	assign o_word_we    = o_touch & i_proc_write;
	assign o_rdata_en   = (state == ST_READY) & i_proc_read & i_hit;
	assign o_fill       = (state == ST_REFILL) & i_mem_ready;
	assign o_way        = (state == ST_READY) ? i_hit_way : victim_r;
	assign o_mem_write  = (state == ST_WRITEBACK);
	assign o_mem_read   = (state == ST_REFILL);

endmodule

`default_nettype wire

// ==== hw/cache_data_store.sv ====
// cache data store with single-word write, whole-line fill and line read for write-back
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module cache_data_store
	import cache_pkg::*;
(
	input  wire         clk,
	input  wire paddr_t i_addr,
	input  wire way_t   i_way,
	input  wire         i_word_we,    // hit write
	input  wire word_t  i_wdata,
	input  wire         i_fill,       // refill from memory
	input  wire line_t  i_fill_line,
	output word_t       o_rdata,
	output line_t       o_line
);

	word_t mem [`CACHE_SETS][`CACHE_WAYS][`CACHE_LINE_WORDS];

	index_t  idx;
	offset_t off;

	assign off = i_addr[`CACHE_OFFSET_W-1:0];
	assign idx = i_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

	// ----------------------------------------
	// read side
	// ----------------------------------------
	assign o_rdata = mem[idx][i_way][off];

	always_comb begin
		for (int k = 0; k < `CACHE_LINE_WORDS; k++)
			o_line[k*`CACHE_WORD_W +: `CACHE_WORD_W] = mem[idx][i_way][k];
	end

	// ----------------------------------------
	// write side
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (i_fill) begin
			for (int k = 0; k < `CACHE_LINE_WORDS; k++)
				mem[idx][i_way][k] <= i_fill_line[k*`CACHE_WORD_W +: `CACHE_WORD_W];
		end else if (i_word_we) begin
			mem[idx][i_way][off] <= i_wdata;   // fill and hit never overlap
		end
	end

endmodule

`default_nettype wire

// ==== hw/cache_pkg.sv ====
// cache package with the shared vector types and the controller state encoding
`default_nettype none

`include "cache_macros.svh"

package cache_pkg;

	// ----------------------------------------
	// data and address vectors
	// ----------------------------------------
	typedef logic [`CACHE_WORD_W-1:0]  word_t;
	typedef logic [`CACHE_PADDR_W-1:0] paddr_t;   // {tag, index, offset}
	typedef logic [`CACHE_LADDR_W-1:0] laddr_t;   // {tag, index}
	typedef logic [`CACHE_LINE_W-1:0]  line_t;    // word 0 in the low bits

	// address fields
	typedef logic [`CACHE_TAG_W-1:0]    tag_t;
	typedef logic [`CACHE_INDEX_W-1:0]  index_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

	// one of two ways
	typedef logic way_t;

	// ----------------------------------------
	// controller states
	// ----------------------------------------
	typedef enum logic [1:0] {
		ST_READY     = 2'd0,   // serving hits
		ST_WRITEBACK = 2'd1,   // victim line out to memory
		ST_REFILL    = 2'd2    // missing line in from memory
	} cache_state_e;

endpackage

`default_nettype wire

// ==== hw/cache_tag_store.sv ====
// cache tag store holding tags, valid bits and MRU pointers, with hit and victim lookup
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module cache_tag_store
	import cache_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	input  wire paddr_t i_addr,
	input  wire         i_touch,      // completed hit
	input  wire         i_fill,       // refill done, install tag
	input  wire way_t   i_fill_way,
	output logic        o_hit,
	output way_t        o_hit_way,
	output way_t        o_victim_way,
	output logic        o_victim_valid,
	output tag_t        o_victim_tag
);

	// ----------------------------------------
	// storage
	// ----------------------------------------
	tag_t                   tags  [`CACHE_SETS][`CACHE_WAYS];
	logic [`CACHE_WAYS-1:0] valid [`CACHE_SETS];
	way_t                   mru   [`CACHE_SETS];   // most recently used way

	index_t idx;
	tag_t   addr_tag;
	logic   hit_any;
	way_t   hit_way;
	way_t   victim;

	assign idx      = i_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign addr_tag = i_addr[`CACHE_PADDR_W-1:`CACHE_OFFSET_W+`CACHE_INDEX_W];

	// ----------------------------------------
	// lookup
	// ----------------------------------------
	always_comb begin
		hit_any = 1'b0;
		hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (valid[idx][w] && (tags[idx][w] == addr_tag)) begin
				hit_any = 1'b1;
				hit_way = way_t'(w);
			end
		end
	end

	// first invalid way wins, else the one not used last
	always_comb begin
		victim = ~mru[idx];
		for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
			if (!valid[idx][w])
				victim = way_t'(w);
		end
	end

	assign o_hit          = hit_any;
	assign o_hit_way      = hit_way;
	assign o_victim_way   = victim;
	assign o_victim_valid = valid[idx][victim];
	assign o_victim_tag   = tags[idx][victim];   // only meaningful when valid

	// ----------------------------------------
	// update
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < `CACHE_SETS; s++) begin
				valid[s] <= '0;
				mru[s]   <= '0;
			end
		end else if (i_fill) begin
			valid[idx][i_fill_way] <= 1'b1;
			mru[idx]               <= i_fill_way;
		end else if (i_touch) begin
			mru[idx] <= hit_way;
		end
	end

	always_ff @(posedge clk) begin
		if (i_fill)
			tags[idx][i_fill_way] <= addr_tag;
	end

endmodule

`default_nettype wire

// ==== hw/cache_top.sv ====
// cache top level joining controller, tag store and data store to the two ports
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module cache_top
	import cache_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	// processor side
	input  wire         i_proc_read,
	input  wire         i_proc_write,
	input  wire paddr_t i_proc_addr,
	input  wire word_t  i_proc_wdata,
	output word_t       o_proc_rdata,
	output logic        o_proc_stall,
	// memory side
	output logic        o_mem_read,
	output logic        o_mem_write,
	output laddr_t      o_mem_addr,
	output line_t       o_mem_wdata,
	input  wire line_t  i_mem_rdata,
	input  wire         i_mem_ready
);

	logic   hit;
	way_t   hit_way;
	way_t   victim_way;
	logic   victim_valid;
	tag_t   victim_tag;
	logic   touch;
	logic   word_we;
	logic   fill;
	way_t   way;
	logic   mem_write;
	logic   rdata_en;
	word_t  rdata;
	index_t addr_index;

	assign addr_index = i_proc_addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];

	cache_ctrl u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_proc_read    (i_proc_read),
		.i_proc_write   (i_proc_write),
		.i_hit          (hit),
		.i_hit_way      (hit_way),
		.i_victim_way   (victim_way),
		.i_victim_valid (victim_valid),
		.i_mem_ready    (i_mem_ready),
		.o_proc_stall   (o_proc_stall),
		.o_touch        (touch),
		.o_word_we      (word_we),
		.o_fill         (fill),
		.o_way          (way),
		.o_mem_read     (o_mem_read),
		.o_mem_write    (mem_write),
		.o_rdata_en     (rdata_en)
	);

	cache_tag_store u_tags (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_addr         (i_proc_addr),
		.i_touch        (touch),
		.i_fill         (fill),
		.i_fill_way     (way),
		.o_hit          (hit),
		.o_hit_way      (hit_way),
		.o_victim_way   (victim_way),
		.o_victim_valid (victim_valid),
		.o_victim_tag   (victim_tag)
	);

	cache_data_store u_data (
		.clk         (clk),
		.i_addr      (i_proc_addr),
		.i_way       (way),
		.i_word_we   (word_we),
		.i_wdata     (i_proc_wdata),
		.i_fill      (fill),
		.i_fill_line (i_mem_rdata),
		.o_rdata     (rdata),
		.o_line      (o_mem_wdata)   // victim line during write-back
	);

	// ----------------------------------------
	// port muxing
	// ----------------------------------------
	assign o_mem_write  = mem_write;
	assign o_mem_addr   = mem_write ? {victim_tag, addr_index}
	                                : i_proc_addr[`CACHE_PADDR_W-1:`CACHE_OFFSET_W];
	assign o_proc_rdata = rdata_en ? rdata : '1;   // all ones when idle

endmodule

`default_nettype wire

// ==== include/cache_macros.svh ====
// cache geometry and field widths for the two-way set-associative block cache
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ----------------------------------------
// geometry
// ----------------------------------------
`define CACHE_SETS        4
`define CACHE_WAYS        2
`define CACHE_LINE_WORDS  4

// ----------------------------------------
// widths
// ----------------------------------------
`define CACHE_WORD_W      32
`define CACHE_PADDR_W     30   // word address from the processor
`define CACHE_OFFSET_W    2    // word in line
`define CACHE_INDEX_W     2    // set select
`define CACHE_TAG_W       26   // paddr minus index and offset

// memory side works on whole lines
`define CACHE_LADDR_W     28   // tag then index
`define CACHE_LINE_W      128

`endif

// ==== testbench/tb_cache.sv ====
// block cache testbench with line memory model, shadow reference and random traffic
`timescale 1ns/1ns
`default_nettype none

`include "cache_macros.svh"

module tb_cache
	import cache_pkg::*;
();

	localparam int          DRIVE_DLY  = 1;
	localparam int          NUM_WORDS  = 64;
	localparam int          NUM_LINES  = NUM_WORDS / `CACHE_LINE_WORDS;
	localparam int          NUM_RANDOM = 1200;
	localparam int unsigned MAX_CYCLES = 40000;
	localparam logic [31:0] LCG_SEED   = 32'd3;

	logic   clk;
	logic   rst_n;
	logic   proc_read;
	logic   proc_write;
	paddr_t proc_addr;
	word_t  proc_wdata;
	word_t  proc_rdata;
	logic   proc_stall;
	logic   mem_read;
	logic   mem_write;
	laddr_t mem_addr;
	line_t  mem_wdata;
	line_t  mem_rdata;
	logic   mem_ready;

	word_t       shadow    [NUM_WORDS];   // what the processor should see
	line_t       mem_lines [NUM_LINES];
	int unsigned cycle_cnt   = 0;
	int unsigned reads_done  = 0;
	int unsigned writes_done = 0;
	int unsigned mem_writes  = 0;
	string       test_name   = "reset";

	tb_clkgen #(.PERIOD_NS(8), .RESET_CYCLES(3)) u_clkgen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	cache_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_proc_read  (proc_read),
		.i_proc_write (proc_write),
		.i_proc_addr  (proc_addr),
		.i_proc_wdata (proc_wdata),
		.o_proc_rdata (proc_rdata),
		.o_proc_stall (proc_stall),
		.o_mem_read   (mem_read),
		.o_mem_write  (mem_write),
		.o_mem_addr   (mem_addr),
		.o_mem_wdata  (mem_wdata),
		.i_mem_rdata  (mem_rdata),
		.i_mem_ready  (mem_ready)
	);

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	function automatic word_t init_word(input int unsigned waddr);
		return (waddr * 32'h9e37_79b9) ^ {waddr[15:0], 16'h5a5a} ^ 32'h0bad_cafe;
	endfunction

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic word_t ref_word(input paddr_t addr);
		return shadow[addr[5:0]];
	endfunction

	function automatic line_t shadow_line(input laddr_t laddr);
		line_t line;
		for (int k = 0; k < `CACHE_LINE_WORDS; k++)
			line[k*`CACHE_WORD_W +: `CACHE_WORD_W] = shadow[{laddr[3:0], k[1:0]}];
		return line;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input line_t expected, input line_t actual);
		if (expected !== actual) begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "run stopped");
		end
	endtask

	task automatic hold_check(input logic is_write, input laddr_t addr);
		logic strobe;
		strobe = is_write ? mem_write : mem_read;
		check_value("mem strobe held", line_t'(1'b1), line_t'(strobe));
		check_value("mem addr stable", line_t'(addr), line_t'(mem_addr));
	endtask

	// one request, held until the cache stops stalling
	task automatic issue(input logic is_write, input paddr_t addr, input word_t data);
		proc_read  = ~is_write;
		proc_write = is_write;
		proc_addr  = addr;
		proc_wdata = data;
		@(negedge clk);
		while (proc_stall)
			@(negedge clk);
		@(posedge clk);
		#DRIVE_DLY;
		proc_read  = 1'b0;
		proc_write = 1'b0;
	endtask

	// ----------------------------------------
	// memory model
	// ----------------------------------------
	initial begin : memory_model
		int unsigned lat;
		logic        is_write;
		laddr_t      addr_hold;
		logic [31:0] mem_lcg;
		mem_lcg   = LCG_SEED;
		mem_ready = 1'b0;
		mem_rdata = '0;
		for (int l = 0; l < NUM_LINES; l++)
			for (int k = 0; k < `CACHE_LINE_WORDS; k++)
				mem_lines[l][k*`CACHE_WORD_W +: `CACHE_WORD_W] = init_word(l * 4 + k);
		forever begin
			@(negedge clk);
			if (rst_n && (mem_read || mem_write)) begin
				is_write  = mem_write;
				addr_hold = mem_addr;
				if (addr_hold >= laddr_t'(NUM_LINES))
					fail_now("memory access outside the modelled line range");
				mem_lcg = lcg_step(mem_lcg);
				lat     = 1 + (mem_lcg[31:16] % 6);   // 1 to 6 cycles
				repeat (lat - 1) begin
					@(negedge clk);
					hold_check(is_write, addr_hold);
				end
				@(posedge clk);
				#DRIVE_DLY;
				mem_ready = 1'b1;
				if (!is_write)
					mem_rdata = mem_lines[addr_hold[3:0]];
				@(negedge clk);
				hold_check(is_write, addr_hold);
				if (is_write) begin
					// no dirty bit, so every victim must match the shadow
					check_value("writeback line", shadow_line(addr_hold), mem_wdata);
					mem_lines[addr_hold[3:0]] = mem_wdata;
					mem_writes++;
				end
				@(posedge clk);
				#DRIVE_DLY;
				mem_ready = 1'b0;
			end
		end
	end

	always @(negedge clk) begin
		if (mem_read && mem_write)
			fail_now("memory read and write strobes are high together");
	end

	// ----------------------------------------
	// compare at every completed request
	// ----------------------------------------
	initial begin : compare
		for (int a = 0; a < NUM_WORDS; a++)
			shadow[a] = init_word(a);
		forever begin
			@(negedge clk);
			// data port idles at all ones without a read
			if (rst_n && !proc_read)
				check_value("idle rdata", line_t'({`CACHE_WORD_W{1'b1}}), line_t'(proc_rdata));
			if (rst_n && !proc_stall) begin
				if (proc_read) begin
					check_value(test_name, line_t'(ref_word(proc_addr)), line_t'(proc_rdata));
					reads_done++;
				end else if (proc_write) begin
					shadow[proc_addr[5:0]] = proc_wdata;   // lands at the next edge
					writes_done++;
				end
			end
		end
	end

	initial begin : timeout
		forever begin
			@(posedge clk);
			cycle_cnt++;
			if (cycle_cnt >= MAX_CYCLES)
				fail_now($sformatf("timeout after %0d cycles, the run did not finish", cycle_cnt));
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin : stimulus
		logic [31:0] stim_lcg;
		int unsigned wb_before;
		paddr_t      addr;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		stim_lcg   = LCG_SEED;

		@(posedge rst_n);
		@(posedge clk);
		#DRIVE_DLY;
		@(negedge clk);
		check_value("idle stall", '0, line_t'(proc_stall));
		check_value("idle mem read", '0, line_t'(mem_read));
		check_value("idle mem write", '0, line_t'(mem_write));
		@(posedge clk);
		#DRIVE_DLY;

		test_name = "reset_reads";   // untouched lines give the pattern
		for (int a = 0; a < 16; a++)
			issue(1'b0, paddr_t'(a), '0);

		test_name = "write_read";
		issue(1'b1, paddr_t'(5), 32'hdead_beef);
		issue(1'b0, paddr_t'(5), '0);
		issue(1'b0, paddr_t'(4), '0);
		issue(1'b0, paddr_t'(6), '0);
		issue(1'b0, paddr_t'(7), '0);

		// three tags into set 0
		test_name = "eviction";
		wb_before = mem_writes;
		issue(1'b1, paddr_t'(6'h01), 32'h1111_0001);
		issue(1'b1, paddr_t'(6'h11), 32'h2222_0011);
		issue(1'b1, paddr_t'(6'h21), 32'h3333_0021);
		issue(1'b0, paddr_t'(6'h01), '0);
		issue(1'b0, paddr_t'(6'h11), '0);
		issue(1'b0, paddr_t'(6'h21), '0);
		issue(1'b0, paddr_t'(6'h20), '0);
		if (mem_writes == wb_before)
			fail_now("eviction test saw no line written back to memory");

		test_name = "random";
		for (int n = 0; n < NUM_RANDOM; n++) begin
			stim_lcg = lcg_step(stim_lcg);
			addr     = paddr_t'(stim_lcg[21:16]);
			if (stim_lcg[28]) begin
				stim_lcg = lcg_step(stim_lcg);
				issue(1'b1, addr, stim_lcg);
			end else begin
				issue(1'b0, addr, '0);
			end
		end

		@(posedge clk);
		$display("%0d reads, %0d writes, %0d line write-backs in %0d cycles",
		         reads_done, writes_done, mem_writes, cycle_cnt);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
// testbench clock and reset generator, reset held low for a few clock cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#1 o_rst_n = 1'b1;   // release clear of the edge
	end

endmodule

`default_nettype wire
